/* project.f */
+incdir+verif
src/ccip_pkg.sv
src/sniff_pkg.sv
src/c0_read_checker.sv
src/c1_mcl_checker.sv
src/mmio_rsp_tracker.sv
src/ccip_sniffer.sv
verif/tb_ccip_sniffer.sv

/* run_sim.sh */
#!/bin/sh
# Build the CCI-P checker testbench with Verilator and run it.
# The exit status of the simulation is the test result.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
   -f project.f \
   --top-module tb_ccip_sniffer \
   -Mdir obj_dir

./obj_dir/Vtb_ccip_sniffer

/* src/c0_read_checker.sv */
// ------------------------------
// Channel 0 read request checker
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module c0_read_checker (
   input  logic                  clk,
   input  logic                  ase_reset,
   input  logic                  soft_reset,
   input  ccip_pkg::c0_tx_t      c0_tx,
   input  logic                  ch0_realfull,
   output sniff_pkg::sniff_vec_t errors
);

   logic                  is_read;
   sniff_pkg::sniff_vec_t err_n;

   // Only the two read flavours are legal here
   assign is_read = c0_tx.hdr.req_type inside {ccip_pkg::eREQ_RDLINE_S,
                                               ccip_pkg::eREQ_RDLINE_I};

   always_comb begin
      err_n = '0;
      if (c0_tx.valid) begin
         if (!is_read) begin
            err_n[sniff_pkg::SNIFF_C0TX_INVALID_REQTYPE] = 1'b1;
         end
         else begin
            // 3-line reads do not exist
            if (c0_tx.hdr.cl_len == ccip_pkg::eCL_LEN_3) begin
               err_n[sniff_pkg::SNIFF_C0TX_3CL_REQUEST] = 1'b1;
            end
            // 2-line needs even address
            if ((c0_tx.hdr.cl_len == ccip_pkg::eCL_LEN_2) && c0_tx.hdr.address[0]) begin
               err_n[sniff_pkg::SNIFF_C0TX_ADDRALIGN_2] = 1'b1;
            end
            // 4-line needs low two bits clear
            if ((c0_tx.hdr.cl_len == ccip_pkg::eCL_LEN_4) &&
                (c0_tx.hdr.address[1:0] != 2'b00)) begin
               err_n[sniff_pkg::SNIFF_C0TX_ADDRALIGN_4] = 1'b1;
            end
         end
         // Any valid beat into a full channel
         if (ch0_realfull) begin
            err_n[sniff_pkg::SNIFF_C0TX_OVERFLOW] = 1'b1;
         end
         // Traffic while the accelerator is held in soft reset
         if (soft_reset) begin
            err_n[sniff_pkg::SNIFF_C0TX_RESET_IGNORED] = 1'b1;
         end
      end
   end

   // One-cycle error pulses
   always_ff @(posedge clk) begin
      if (ase_reset) begin
         errors <= '0;
      end
      else begin
         errors <= err_n;
      end
   end

endmodule

`default_nettype wire

/* src/c1_mcl_checker.sv */
// ------------------------------
// Channel 1 write request checker
// Multi-line burst tracker FSM
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module c1_mcl_checker (
   input  logic                  clk,
   input  logic                  ase_reset,
   input  logic                  soft_reset,
   input  ccip_pkg::c1_tx_t      c1_tx,
   input  logic                  ch1_realfull,
   output sniff_pkg::sniff_vec_t errors
);

   // Which beat of a burst comes next
   typedef enum logic [1:0] {
      EXP_FIRST = 2'd0,
      EXP_LINE2 = 2'd1,
      EXP_LINE3 = 2'd2,
      EXP_LINE4 = 2'd3
   } mcl_state_e;

   mcl_state_e             state;
   mcl_state_e             state_n;

   // Fields captured on the SOP beat
   ccip_pkg::ccip_vc_e     base_vc;
   ccip_pkg::ccip_req_e    base_req_type;
   ccip_pkg::ccip_cl_len_e base_cl_len;
   logic [1:0]             base_addr_lo;

   logic                   is_write;
   logic                   is_fence;
   logic                   burst_start;
   logic [1:0]             beat_idx;
   logic [1:0]             exp_addr_lo;
   sniff_pkg::sniff_vec_t  err_n;

   assign is_write = c1_tx.valid &&
                     (c1_tx.hdr.req_type inside {ccip_pkg::eREQ_WRLINE_I,
                                                 ccip_pkg::eREQ_WRLINE_M});
   assign is_fence = c1_tx.valid && (c1_tx.hdr.req_type == ccip_pkg::eREQ_WRFENCE);

   // Multi-line SOP write seen while idle
   assign burst_start = (state == EXP_FIRST) && is_write && c1_tx.hdr.sop &&
                        (c1_tx.hdr.cl_len inside {ccip_pkg::eCL_LEN_2,
                                                  ccip_pkg::eCL_LEN_4});

   // Offset of the current beat from the base line
   always_comb begin
      case (state)
         EXP_LINE2: beat_idx = 2'd1;
         EXP_LINE3: beat_idx = 2'd2;
         EXP_LINE4: beat_idx = 2'd3;
         default:   beat_idx = 2'd0;
      endcase
   end

   // Wraps modulo 4
   assign exp_addr_lo = base_addr_lo + beat_idx;

   always_comb begin
      state_n = state;
      err_n   = '0;

      // Checks that hold in every state
      if (c1_tx.valid && !(is_write || is_fence)) begin
         err_n[sniff_pkg::SNIFF_C1TX_INVALID_REQTYPE] = 1'b1;
      end
      if (c1_tx.valid && ch1_realfull) begin
         err_n[sniff_pkg::SNIFF_C1TX_OVERFLOW] = 1'b1;
      end
      if (c1_tx.valid && soft_reset) begin
         err_n[sniff_pkg::SNIFF_C1TX_RESET_IGNORED] = 1'b1;
      end

      case (state)
         EXP_FIRST: begin
            // First write of anything must carry SOP
            if (is_write && !c1_tx.hdr.sop) begin
               err_n[sniff_pkg::SNIFF_C1TX_SOP_NOT_SET] = 1'b1;
            end
            if (is_write && c1_tx.hdr.sop) begin
               if (c1_tx.hdr.cl_len == ccip_pkg::eCL_LEN_3) begin
                  err_n[sniff_pkg::SNIFF_C1TX_3CL_REQUEST] = 1'b1;
               end
               if ((c1_tx.hdr.cl_len == ccip_pkg::eCL_LEN_2) && c1_tx.hdr.address[0]) begin
                  err_n[sniff_pkg::SNIFF_C1TX_ADDRALIGN_2] = 1'b1;
               end
               if ((c1_tx.hdr.cl_len == ccip_pkg::eCL_LEN_4) &&
                   (c1_tx.hdr.address[1:0] != 2'b00)) begin
                  err_n[sniff_pkg::SNIFF_C1TX_ADDRALIGN_4] = 1'b1;
               end
            end
            // Single lines and fences stay here
            if (burst_start) begin
               state_n = EXP_LINE2;
            end
         end

         default: begin
            // Fence cannot split a burst, state holds
            if (is_fence) begin
               err_n[sniff_pkg::SNIFF_C1TX_WRFENCE_IN_MCL1TO3] = 1'b1;
            end
            if (is_write) begin
               if (c1_tx.hdr.sop) begin
                  err_n[sniff_pkg::SNIFF_C1TX_SOP_SET_MCL1TO3] = 1'b1;
               end
               if (c1_tx.hdr.vc_sel != base_vc) begin
                  err_n[sniff_pkg::SNIFF_C1TX_UNEXP_VCSEL] = 1'b1;
               end
               if (c1_tx.hdr.req_type != base_req_type) begin
                  err_n[sniff_pkg::SNIFF_C1TX_UNEXP_REQTYPE] = 1'b1;
               end
               if (c1_tx.hdr.address[1:0] != exp_addr_lo) begin
                  err_n[sniff_pkg::SNIFF_C1TX_UNEXP_ADDR] = 1'b1;
               end
               // 2-line ends after beat 2, 4-line after beat 4
               if ((state == EXP_LINE4) ||
                   ((state == EXP_LINE2) && (base_cl_len == ccip_pkg::eCL_LEN_2))) begin
                  state_n = EXP_FIRST;
               end
               else if (state == EXP_LINE2) begin
                  state_n = EXP_LINE3;
               end
               else begin
                  state_n = EXP_LINE4;
               end
            end
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (ase_reset) begin
         state  <= EXP_FIRST;
         errors <= '0;
      end
      else begin
         state  <= state_n;
         errors <= err_n;
      end
   end

   // Base header of the burst
   always_ff @(posedge clk) begin
      if (burst_start) begin
         base_vc       <= c1_tx.hdr.vc_sel;
         base_req_type <= c1_tx.hdr.req_type;
         base_cl_len   <= c1_tx.hdr.cl_len;
         base_addr_lo  <= c1_tx.hdr.address[1:0];
      end
   end

endmodule

`default_nettype wire

/* src/ccip_pkg.sv */
// ------------------------------
// CCI-P request header types
// Request, length and VC enums
// MMIO request and response types
// ------------------------------
`default_nettype none

package ccip_pkg;

   // Bus widths
   localparam int CCIP_ADDR_WIDTH  = 42;
   localparam int CCIP_MDATA_WIDTH = 16;
   localparam int MMIO_TID_WIDTH   = 4;
   // One tracker entry per TID
   localparam int MMIO_TID_COUNT   = 2**MMIO_TID_WIDTH;

   // Request type, other encodings are still possible on the bus
   typedef enum logic [3:0] {
      eREQ_RDLINE_S = 4'h0,
      eREQ_RDLINE_I = 4'h1,
      eREQ_WRLINE_I = 4'h2,
      eREQ_WRLINE_M = 4'h3,
      eREQ_WRFENCE  = 4'h4
   } ccip_req_e;

   // Number of cache lines, 3 lines is illegal
   typedef enum logic [1:0] {
      eCL_LEN_1 = 2'b00,
      eCL_LEN_2 = 2'b01,
      eCL_LEN_3 = 2'b10,
      eCL_LEN_4 = 2'b11
   } ccip_cl_len_e;

   typedef enum logic [1:0] {
      eVC_VA  = 2'b00,
      eVC_VL0 = 2'b01,
      eVC_VH0 = 2'b10,
      eVC_VH1 = 2'b11
   } ccip_vc_e;

   // Channel 0 read header
   typedef struct packed {
      ccip_vc_e                    vc_sel;
      ccip_cl_len_e                cl_len;
      ccip_req_e                   req_type;
      logic [CCIP_ADDR_WIDTH-1:0]  address;
      logic [CCIP_MDATA_WIDTH-1:0] mdata;
   } c0_req_hdr_t;

   // Channel 1 write header, sop marks first beat
   typedef struct packed {
      ccip_vc_e                    vc_sel;
      logic                        sop;
      ccip_cl_len_e                cl_len;
      ccip_req_e                   req_type;
      logic [CCIP_ADDR_WIDTH-1:0]  address;
      logic [CCIP_MDATA_WIDTH-1:0] mdata;
   } c1_req_hdr_t;

   typedef struct packed {
      logic        valid;
      c0_req_hdr_t hdr;
   } c0_tx_t;

   typedef struct packed {
      logic        valid;
      c1_req_hdr_t hdr;
   } c1_tx_t;

   typedef logic [MMIO_TID_WIDTH-1:0] mmio_tid_t;

   // Host MMIO read request
   typedef struct packed {
      logic      valid;
      mmio_tid_t tid;
   } mmio_req_t;

   // Accelerator MMIO read response
   typedef struct packed {
      logic      valid;
      mmio_tid_t tid;
   } mmio_rsp_t;

endpackage

`default_nettype wire

/* src/ccip_sniffer.sv */
// ------------------------------
// CCI-P protocol checker top
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module ccip_sniffer (
   input  logic                  clk,
   input  logic                  ase_reset,
   input  logic                  soft_reset,
   input  ccip_pkg::c0_tx_t      c0_tx,
   input  ccip_pkg::c1_tx_t      c1_tx,
   input  ccip_pkg::mmio_rsp_t   c2_rsp,
   input  ccip_pkg::mmio_req_t   mmio_req,
   input  logic                  ch0_realfull,
   input  logic                  ch1_realfull,
   output sniff_pkg::sniff_vec_t error_code
);

   // Each checker only sets its own bits
   sniff_pkg::sniff_vec_t err_c0;
   sniff_pkg::sniff_vec_t err_c1;
   sniff_pkg::sniff_vec_t err_mmio;

   // Read requests
   c0_read_checker u_c0_read_checker (
      .clk          (clk),
      .ase_reset    (ase_reset),
      .soft_reset   (soft_reset),
      .c0_tx        (c0_tx),
      .ch0_realfull (ch0_realfull),
      .errors       (err_c0)
   );

   // Write requests and bursts
   c1_mcl_checker u_c1_mcl_checker (
      .clk          (clk),
      .ase_reset    (ase_reset),
      .soft_reset   (soft_reset),
      .c1_tx        (c1_tx),
      .ch1_realfull (ch1_realfull),
      .errors       (err_c1)
   );

   // MMIO read responses
   mmio_rsp_tracker u_mmio_rsp_tracker (
      .clk        (clk),
      .ase_reset  (ase_reset),
      .soft_reset (soft_reset),
      .mmio_req   (mmio_req),
      .c2_rsp     (c2_rsp),
      .errors     (err_mmio)
   );

   assign error_code = err_c0 | err_c1 | err_mmio;

endmodule

`default_nettype wire

/* src/mmio_rsp_tracker.sv */
// ------------------------------
// MMIO read response tracker
// Per-TID active flag and timer
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module mmio_rsp_tracker (
   input  logic                  clk,
   input  logic                  ase_reset,
   input  logic                  soft_reset,
   input  ccip_pkg::mmio_req_t   mmio_req,
   input  ccip_pkg::mmio_rsp_t   c2_rsp,
   output sniff_pkg::sniff_vec_t errors
);

   typedef logic [sniff_pkg::MMIO_TIMER_WIDTH-1:0] timer_t;

   logic [ccip_pkg::MMIO_TID_COUNT-1:0] active;
   timer_t                              timer [ccip_pkg::MMIO_TID_COUNT];
   logic [ccip_pkg::MMIO_TID_COUNT-1:0] req_hit;
   logic [ccip_pkg::MMIO_TID_COUNT-1:0] rsp_hit;
   logic [ccip_pkg::MMIO_TID_COUNT-1:0] timeout_hit;
   sniff_pkg::sniff_vec_t               err_n;

   // Decode both TIDs per entry
   for (genvar i = 0; i < ccip_pkg::MMIO_TID_COUNT; i++) begin : g_tid
      assign req_hit[i] = mmio_req.valid && (mmio_req.tid == ccip_pkg::mmio_tid_t'(i));
      assign rsp_hit[i] = c2_rsp.valid && (c2_rsp.tid == ccip_pkg::mmio_tid_t'(i));
      // Fires on the one cycle the timer sits at the limit
      assign timeout_hit[i] = active[i] &&
                              (timer[i] == timer_t'(sniff_pkg::MMIO_RSP_TIMEOUT));
   end

   always_ff @(posedge clk) begin
      if (ase_reset) begin
         active <= '0;
         for (int i = 0; i < ccip_pkg::MMIO_TID_COUNT; i++) begin
            timer[i] <= '0;
         end
      end
      else begin
         for (int i = 0; i < ccip_pkg::MMIO_TID_COUNT; i++) begin
            // A new request wins over a response to the same TID
            if (req_hit[i]) begin
               active[i] <= 1'b1;
               timer[i]  <= '0;
            end
            else if (rsp_hit[i]) begin
               active[i] <= 1'b0;
               timer[i]  <= '0;
            end
            // Park one past the limit so the timeout pulses once
            else if (active[i] &&
                     (timer[i] != timer_t'(sniff_pkg::MMIO_RSP_TIMEOUT + 1))) begin
               timer[i] <= timer[i] + 1'b1;
            end
         end
      end
   end

   always_comb begin
      err_n = '0;
      err_n[sniff_pkg::MMIO_RDRSP_TIMEOUT] = |timeout_hit;
      // Response to a TID nobody asked for
      if (c2_rsp.valid && !active[c2_rsp.tid]) begin
         err_n[sniff_pkg::MMIO_RDRSP_UNSOLICITED] = 1'b1;
      end
      if (c2_rsp.valid && soft_reset) begin
         err_n[sniff_pkg::MMIO_RDRSP_RESET_IGNORED] = 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (ase_reset) begin
         errors <= '0;
      end
      else begin
         errors <= err_n;
      end
   end

endmodule

`default_nettype wire

/* src/sniff_pkg.sv */
// ------------------------------
// Checker error codes and vector
// MMIO response timeout constants
// ------------------------------
`default_nettype none

package sniff_pkg;

   localparam int SNIFF_VECTOR_WIDTH = 21;

   // Cycles an MMIO read may stay unanswered
   localparam int MMIO_RSP_TIMEOUT = 64;
   // Counter must hold timeout plus one
   localparam int MMIO_TIMER_WIDTH = 7;

   // Bit index into the error vector
   typedef enum logic [4:0] {
      // Channel 0
      SNIFF_C0TX_INVALID_REQTYPE   = 5'd0,
      SNIFF_C0TX_OVERFLOW          = 5'd1,
      SNIFF_C0TX_ADDRALIGN_2       = 5'd2,
      SNIFF_C0TX_ADDRALIGN_4       = 5'd3,
      SNIFF_C0TX_RESET_IGNORED     = 5'd4,
      SNIFF_C0TX_3CL_REQUEST       = 5'd5,
      // Channel 1
      SNIFF_C1TX_INVALID_REQTYPE   = 5'd6,
      SNIFF_C1TX_OVERFLOW          = 5'd7,
      SNIFF_C1TX_ADDRALIGN_2       = 5'd8,
      SNIFF_C1TX_ADDRALIGN_4       = 5'd9,
      SNIFF_C1TX_RESET_IGNORED     = 5'd10,
      SNIFF_C1TX_3CL_REQUEST       = 5'd11,
      SNIFF_C1TX_UNEXP_VCSEL       = 5'd12,
      SNIFF_C1TX_UNEXP_ADDR        = 5'd13,
      SNIFF_C1TX_UNEXP_REQTYPE     = 5'd14,
      SNIFF_C1TX_SOP_NOT_SET       = 5'd15,
      SNIFF_C1TX_SOP_SET_MCL1TO3   = 5'd16,
      SNIFF_C1TX_WRFENCE_IN_MCL1TO3 = 5'd17,
      // MMIO responses
      MMIO_RDRSP_TIMEOUT           = 5'd18,
      MMIO_RDRSP_UNSOLICITED       = 5'd19,
      MMIO_RDRSP_RESET_IGNORED     = 5'd20
   } sniff_code_e;

   typedef logic [SNIFF_VECTOR_WIDTH-1:0] sniff_vec_t;

endpackage

`default_nettype wire

/* verif/tb_ref_model.svh */
// ------------------------------
// Reference model state
// Expected error vectors per channel
// ------------------------------
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Channel 1 burst model, zero beats left means idle
int                  burst_left;
int                  burst_beat;
ccip_pkg::ccip_vc_e  burst_vc;
ccip_pkg::ccip_req_e burst_type;
int                  burst_addr_lo;

// MMIO model, cycle of the last request per TID
bit                  tid_open  [ccip_pkg::MMIO_TID_COUNT];
int                  tid_stamp [ccip_pkg::MMIO_TID_COUNT];

function automatic void ref_reset();
   burst_left = 0;
   burst_beat = 0;
   for (int t = 0; t < ccip_pkg::MMIO_TID_COUNT; t++) begin
      tid_open[t]  = 1'b0;
      tid_stamp[t] = 0;
   end
endfunction

// Reads only, lengths of 1, 2 or 4 lines aligned to their size
function automatic sniff_pkg::sniff_vec_t ref_c0(input ccip_pkg::c0_tx_t tx,
                                                 input logic full, input logic srst);
   sniff_pkg::sniff_vec_t v;
   int                    lines;
   v = '0;
   if (!tx.valid) begin
      return v;
   end
   lines = int'(tx.hdr.cl_len) + 1;
   if (tx.hdr.req_type != ccip_pkg::eREQ_RDLINE_S &&
       tx.hdr.req_type != ccip_pkg::eREQ_RDLINE_I) begin
      v[sniff_pkg::SNIFF_C0TX_INVALID_REQTYPE] = 1'b1;
   end
   else if (lines == 3) begin
      v[sniff_pkg::SNIFF_C0TX_3CL_REQUEST] = 1'b1;
   end
   else if (lines > 1 && (int'(tx.hdr.address[1:0]) % lines) != 0) begin
      v[(lines == 2) ? sniff_pkg::SNIFF_C0TX_ADDRALIGN_2 : sniff_pkg::SNIFF_C0TX_ADDRALIGN_4] = 1'b1;
   end
   v[sniff_pkg::SNIFF_C0TX_OVERFLOW]      = full;
   v[sniff_pkg::SNIFF_C0TX_RESET_IGNORED] = srst;
   return v;
endfunction

// Writes and fences, bursts follow the SOP beat
function automatic sniff_pkg::sniff_vec_t ref_c1(input ccip_pkg::c1_tx_t tx,
                                                 input logic full, input logic srst);
   sniff_pkg::sniff_vec_t v;
   bit                    wr;
   bit                    fence;
   int                    lines;
   v = '0;
   if (!tx.valid) begin
      return v;
   end
   wr    = (tx.hdr.req_type == ccip_pkg::eREQ_WRLINE_I) ||
           (tx.hdr.req_type == ccip_pkg::eREQ_WRLINE_M);
   fence = (tx.hdr.req_type == ccip_pkg::eREQ_WRFENCE);
   lines = int'(tx.hdr.cl_len) + 1;
   v[sniff_pkg::SNIFF_C1TX_INVALID_REQTYPE] = !(wr || fence);
   v[sniff_pkg::SNIFF_C1TX_OVERFLOW]        = full;
   v[sniff_pkg::SNIFF_C1TX_RESET_IGNORED]   = srst;
   if (burst_left == 0) begin
      if (wr && !tx.hdr.sop) begin
         v[sniff_pkg::SNIFF_C1TX_SOP_NOT_SET] = 1'b1;
      end
      else if (wr) begin
         v[sniff_pkg::SNIFF_C1TX_3CL_REQUEST] = (lines == 3);
         if ((lines == 2 || lines == 4) && (int'(tx.hdr.address[1:0]) % lines) != 0) begin
            v[(lines == 2) ? sniff_pkg::SNIFF_C1TX_ADDRALIGN_2
                           : sniff_pkg::SNIFF_C1TX_ADDRALIGN_4] = 1'b1;
         end
         // Open a burst, even a misaligned one
         if (lines == 2 || lines == 4) begin
            burst_left    = lines - 1;
            burst_beat    = 1;
            burst_vc      = tx.hdr.vc_sel;
            burst_type    = tx.hdr.req_type;
            burst_addr_lo = int'(tx.hdr.address[1:0]);
         end
      end
   end
   else if (fence) begin
      v[sniff_pkg::SNIFF_C1TX_WRFENCE_IN_MCL1TO3] = 1'b1;
   end
   else if (wr) begin
      v[sniff_pkg::SNIFF_C1TX_SOP_SET_MCL1TO3] = tx.hdr.sop;
      v[sniff_pkg::SNIFF_C1TX_UNEXP_VCSEL]     = (tx.hdr.vc_sel != burst_vc);
      v[sniff_pkg::SNIFF_C1TX_UNEXP_REQTYPE]   = (tx.hdr.req_type != burst_type);
      v[sniff_pkg::SNIFF_C1TX_UNEXP_ADDR]      =
         (int'(tx.hdr.address[1:0]) != (burst_addr_lo + burst_beat) % 4);
      burst_beat = burst_beat + 1;
      burst_left = burst_left - 1;
   end
   return v;
endfunction

// Responses close TIDs, a same-cycle request reopens
function automatic sniff_pkg::sniff_vec_t ref_mmio(input ccip_pkg::mmio_req_t req,
                                                   input ccip_pkg::mmio_rsp_t rsp,
                                                   input logic srst, input int cyc);
   sniff_pkg::sniff_vec_t v;
   v = '0;
   for (int t = 0; t < ccip_pkg::MMIO_TID_COUNT; t++) begin
      if (tid_open[t] && (cyc - tid_stamp[t] == sniff_pkg::MMIO_RSP_TIMEOUT + 1)) begin
         v[sniff_pkg::MMIO_RDRSP_TIMEOUT] = 1'b1;
      end
   end
   if (rsp.valid) begin
      v[sniff_pkg::MMIO_RDRSP_UNSOLICITED]   = !tid_open[rsp.tid];
      v[sniff_pkg::MMIO_RDRSP_RESET_IGNORED] = srst;
      tid_open[rsp.tid] = 1'b0;
   end
   if (req.valid) begin
      tid_open[req.tid]  = 1'b1;
      tid_stamp[req.tid] = cyc;
   end
   return v;
endfunction

`endif

/* verif/tb_ccip_sniffer.sv */
// ------------------------------
// CCI-P checker testbench
// Stimulus, reference compare, watchdog
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_ccip_sniffer;

   localparam int unsigned SEED = 32'h2585_adf2;
   localparam int N_C0       = 200;
   localparam int N_LEGAL    = 60;
   localparam int N_FAULT    = 180;
   localparam int N_FLOW     = 60;
   localparam int N_ROUNDS   = 4;
   localparam int N_TIMEOUTS = 3;
   localparam int TMO        = sniff_pkg::MMIO_RSP_TIMEOUT;
   // Upper bound of driven cycles with at most 8 per burst
   localparam int STIM_CYCLES = 16 + N_C0 + (N_LEGAL + N_FAULT) * 8 + N_FLOW * 2 +
                                N_ROUNDS * (2 * ccip_pkg::MMIO_TID_COUNT) + 8 +
                                N_TIMEOUTS * (TMO + 12) + 2 * TMO + 64;
   localparam int WATCHDOG_NS = (STIM_CYCLES + TMO + 100) * 4;

   typedef logic [ccip_pkg::CCIP_ADDR_WIDTH-1:0] addr_t;

   // Fault injected into a channel 1 burst
   typedef enum int {
      F_NONE, F_NO_SOP, F_EXTRA_SOP, F_VC, F_REQTYPE,
      F_ADDR, F_FENCE, F_3CL, F_MISALIGN
   } fault_e;

   localparam ccip_pkg::c0_tx_t    C0_IDLE  = '0;
   localparam ccip_pkg::c1_tx_t    C1_IDLE  = '0;
   localparam ccip_pkg::mmio_req_t REQ_IDLE = '0;
   localparam ccip_pkg::mmio_rsp_t RSP_IDLE = '0;

   logic                  clk;
   logic                  ase_reset;
   logic                  soft_reset;
   logic                  ch0_realfull;
   logic                  ch1_realfull;
   ccip_pkg::c0_tx_t      c0_tx;
   ccip_pkg::c1_tx_t      c1_tx;
   ccip_pkg::mmio_rsp_t   c2_rsp;
   ccip_pkg::mmio_req_t   mmio_req;
   sniff_pkg::sniff_vec_t error_code;

   // Expected vector for the edge that just passed
   sniff_pkg::sniff_vec_t exp_vec;
   string                 exp_name;
   string                 test_name;
   bit                    exp_ready;
   int                    cyc;

   `include "tb_ref_model.svh"

   ccip_sniffer DUT (
      .clk          (clk),
      .ase_reset    (ase_reset),
      .soft_reset   (soft_reset),
      .c0_tx        (c0_tx),
      .c1_tx        (c1_tx),
      .c2_rsp       (c2_rsp),
      .mmio_req     (mmio_req),
      .ch0_realfull (ch0_realfull),
      .ch1_realfull (ch1_realfull),
      .error_code   (error_code)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic check_vec(input string name, input sniff_pkg::sniff_vec_t exp,
                            input sniff_pkg::sniff_vec_t act);
      if (act !== exp) begin
         $display("Mismatch %s expected %b actual %b", name, exp, act);
         $display("Test FAILED");
         $fatal(1, "error_code differs from the reference model");
      end
   endtask

   // Falling edge sees stable inputs and outputs
   // Then predict the coming rising edge
   always @(negedge clk) begin
      if (exp_ready) begin
         check_vec(exp_name, exp_vec, error_code);
      end
      if (ase_reset) begin
         ref_reset();
         exp_vec = '0;
      end
      else begin
         exp_vec = ref_c0(c0_tx, ch0_realfull, soft_reset) |
                   ref_c1(c1_tx, ch1_realfull, soft_reset) |
                   ref_mmio(mmio_req, c2_rsp, soft_reset, cyc);
      end
      exp_name  = test_name;
      exp_ready = 1'b1;
      cyc       = cyc + 1;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Test FAILED");
      $fatal(1, "Timeout after %0d ns, stimulus never finished", WATCHDOG_NS);
   end

   function automatic addr_t rand_addr();
      logic [63:0] r;
      r = {$urandom(), $urandom()};
      return r[ccip_pkg::CCIP_ADDR_WIDTH-1:0];
   endfunction

   function automatic ccip_pkg::c0_tx_t rand_c0();
      ccip_pkg::c0_tx_t tx;
      logic [31:0]      r;
      r = $urandom();
      tx.valid        = (r[2:0] != 3'b000);
      tx.hdr.vc_sel   = ccip_pkg::ccip_vc_e'(r[4:3]);
      tx.hdr.cl_len   = ccip_pkg::ccip_cl_len_e'(r[6:5]);
      // Half legal reads so length and alignment get hit
      tx.hdr.req_type = r[7] ? ccip_pkg::ccip_req_e'({3'b000, r[8]})
                             : ccip_pkg::ccip_req_e'(r[12:9]);
      tx.hdr.address  = rand_addr();
      tx.hdr.mdata    = r[28:13];
      return tx;
   endfunction

   function automatic ccip_pkg::c1_tx_t write_beat(input ccip_pkg::ccip_vc_e vc,
                                                   input ccip_pkg::ccip_req_e rtype,
                                                   input addr_t addr,
                                                   input ccip_pkg::ccip_cl_len_e len,
                                                   input logic sop);
      ccip_pkg::c1_tx_t tx;
      tx.valid        = 1'b1;
      tx.hdr.vc_sel   = vc;
      tx.hdr.sop      = sop;
      tx.hdr.cl_len   = len;
      tx.hdr.req_type = rtype;
      tx.hdr.address  = addr;
      tx.hdr.mdata    = addr[15:0];
      return tx;
   endfunction

   function automatic ccip_pkg::mmio_req_t mmio_read(input int tid);
      return '{valid: 1'b1, tid: ccip_pkg::mmio_tid_t'(tid)};
   endfunction

   function automatic ccip_pkg::mmio_rsp_t mmio_answer(input int tid);
      return '{valid: 1'b1, tid: ccip_pkg::mmio_tid_t'(tid)};
   endfunction

   // One clock of stimulus
   task automatic drive(input ccip_pkg::c0_tx_t c0, input ccip_pkg::c1_tx_t c1,
                        input ccip_pkg::mmio_req_t req, input ccip_pkg::mmio_rsp_t rsp,
                        input logic full0, input logic full1, input logic srst);
      @(posedge clk);
      c0_tx        <= c0;
      c1_tx        <= c1;
      mmio_req     <= req;
      c2_rsp       <= rsp;
      ch0_realfull <= full0;
      ch1_realfull <= full1;
      soft_reset   <= srst;
   endtask

   task automatic idle(input int n);
      repeat (n) drive(C0_IDLE, C1_IDLE, REQ_IDLE, RSP_IDLE, 1'b0, 1'b0, 1'b0);
   endtask

   task automatic drive_c1(input ccip_pkg::c1_tx_t c1);
      drive(C0_IDLE, c1, REQ_IDLE, RSP_IDLE, 1'b0, 1'b0, 1'b0);
   endtask

   // Reset with random channel 0 traffic on the bus
   task automatic hold_reset(input int n);
      for (int i = 0; i < n; i++) begin
         drive(rand_c0(), C1_IDLE, REQ_IDLE, RSP_IDLE, 1'b0, 1'b0, 1'b0);
         ase_reset <= 1'b1;
      end
      idle(1);
      ase_reset <= 1'b0;
   endtask

   task automatic send_burst(input int lines, input fault_e fault);
      ccip_pkg::c1_tx_t       beat;
      ccip_pkg::ccip_vc_e     vc;
      ccip_pkg::ccip_req_e    wtype;
      ccip_pkg::ccip_cl_len_e len;
      addr_t                  base;
      logic [31:0]            r;
      int                     n;
      int                     k;
      r     = $urandom();
      vc    = ccip_pkg::ccip_vc_e'(r[1:0]);
      wtype = r[2] ? ccip_pkg::eREQ_WRLINE_M : ccip_pkg::eREQ_WRLINE_I;
      base  = rand_addr();
      // Start on a multiple of the burst length
      if (lines == 2) begin
         base[0] = 1'b0;
      end
      if (lines == 4) begin
         base[1:0] = 2'b00;
      end
      len = (lines == 4) ? ccip_pkg::eCL_LEN_4 :
            (lines == 2) ? ccip_pkg::eCL_LEN_2 : ccip_pkg::eCL_LEN_1;
      n = lines;
      k = (lines > 1) ? int'($urandom_range(1, lines - 1)) : 0;
      case (fault)
         F_NO_SOP:   k = 0;
         // Single beat that never opens a burst
         F_3CL: begin
            len = ccip_pkg::eCL_LEN_3;
            n   = 1;
         end
         F_MISALIGN: base[1:0] = (lines == 2) ? 2'b01 : 2'($urandom_range(1, 3));
         default: ;
      endcase
      for (int i = 0; i < n; i++) begin
         beat = write_beat(vc, wtype, base + addr_t'(i), len, i == 0);
         if (i > 0 && $urandom_range(0, 3) == 0) begin
            idle(1);
         end
         if (i == k) begin
            case (fault)
               F_NO_SOP:    beat.hdr.sop = 1'b0;
               F_EXTRA_SOP: beat.hdr.sop = 1'b1;
               F_VC:        beat.hdr.vc_sel = ccip_pkg::ccip_vc_e'(~vc);
               F_REQTYPE: begin
                  beat.hdr.req_type = (wtype == ccip_pkg::eREQ_WRLINE_I) ?
                                      ccip_pkg::eREQ_WRLINE_M : ccip_pkg::eREQ_WRLINE_I;
               end
               F_ADDR:      beat.hdr.address = beat.hdr.address + addr_t'(1);
               // Fence slips in ahead of this beat
               F_FENCE: begin
                  drive_c1(write_beat(vc, ccip_pkg::eREQ_WRFENCE, rand_addr(),
                                      ccip_pkg::eCL_LEN_1, 1'b0));
               end
               default: ;
            endcase
         end
         drive_c1(beat);
      end
   endtask

   function automatic int pick_lines();
      int r;
      r = int'($urandom_range(0, 2));
      return (r == 0) ? 1 : (r == 1) ? 2 : 4;
   endfunction

   initial begin
      ccip_pkg::c0_tx_t c0;
      ccip_pkg::c1_tx_t c1;
      fault_e           f;
      logic [31:0]      r;
      int               tid;
      int               j;
      int               tmp;
      int               order [ccip_pkg::MMIO_TID_COUNT];

      void'($urandom(SEED));
      ase_reset    = 1'b1;
      soft_reset   = 1'b0;
      ch0_realfull = 1'b0;
      ch1_realfull = 1'b0;
      c0_tx        = C0_IDLE;
      c1_tx        = C1_IDLE;
      c2_rsp       = RSP_IDLE;
      mmio_req     = REQ_IDLE;
      exp_vec      = '0;
      exp_ready    = 1'b0;
      cyc          = 0;
      test_name    = "reset";
      repeat (16) @(posedge clk);
      ase_reset <= 1'b0;

      test_name = "c0_random_headers";
      for (int i = 0; i < N_C0; i++) begin
         drive(rand_c0(), C1_IDLE, REQ_IDLE, RSP_IDLE, 1'b0, 1'b0, 1'b0);
      end
      idle(1);

      test_name = "c1_legal_bursts";
      for (int i = 0; i < N_LEGAL; i++) begin
         send_burst(pick_lines(), F_NONE);
      end
      test_name = "c1_faulty_bursts";
      for (int i = 0; i < N_FAULT; i++) begin
         f = fault_e'($urandom_range(1, 8));
         send_burst($urandom_range(0, 1) ? 4 : 2, f);
      end
      idle(1);

      // Each channel sees its own valid, realfull and soft reset at random
      test_name = "realfull_soft_reset";
      for (int i = 0; i < N_FLOW; i++) begin
         r   = $urandom();
         tid = int'(r[11:8]);
         drive(C0_IDLE, C1_IDLE, mmio_read(tid), RSP_IDLE, 1'b0, 1'b0, 1'b0);
         c0 = rand_c0();
         c0.valid        = r[3];
         c0.hdr.req_type = ccip_pkg::eREQ_RDLINE_S;
         c0.hdr.cl_len   = ccip_pkg::eCL_LEN_1;
         c1 = write_beat(ccip_pkg::eVC_VA, ccip_pkg::eREQ_WRLINE_I, rand_addr(),
                         ccip_pkg::eCL_LEN_1, 1'b1);
         c1.valid = r[4];
         // Single lines with any request type on channel 1 half the time
         c1.hdr.req_type = r[5] ? ccip_pkg::eREQ_WRLINE_I : ccip_pkg::ccip_req_e'(r[15:12]);
         drive(c0, c1, REQ_IDLE, mmio_answer(tid), r[0], r[1], r[2]);
      end
      idle(1);

      test_name = "mmio_random_order";
      for (int rnd = 0; rnd < N_ROUNDS; rnd++) begin
         for (int i = 0; i < ccip_pkg::MMIO_TID_COUNT; i++) begin
            order[i] = i;
         end
         for (int i = ccip_pkg::MMIO_TID_COUNT - 1; i > 0; i--) begin
            j        = int'($urandom_range(0, i));
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
         end
         for (int i = 0; i < ccip_pkg::MMIO_TID_COUNT; i++) begin
            drive(C0_IDLE, C1_IDLE, mmio_read(i), RSP_IDLE, 1'b0, 1'b0, 1'b0);
         end
         for (int i = 0; i < ccip_pkg::MMIO_TID_COUNT; i++) begin
            drive(C0_IDLE, C1_IDLE, REQ_IDLE, mmio_answer(order[i]), 1'b0, 1'b0, 1'b0);
         end
      end
      test_name = "mmio_unsolicited";
      for (int i = 0; i < 4; i++) begin
         drive(C0_IDLE, C1_IDLE, REQ_IDLE, mmio_answer(int'($urandom_range(0, 15))),
               1'b0, 1'b0, 1'b0);
      end
      idle(1);

      // Pulse lands one cycle past the timeout
      // Late answer stays silent
      test_name = "mmio_timeout";
      for (int i = 0; i < N_TIMEOUTS; i++) begin
         tid = int'($urandom_range(0, 15));
         drive(C0_IDLE, C1_IDLE, mmio_read(tid), RSP_IDLE, 1'b0, 1'b0, 1'b0);
         idle(TMO + 8);
         drive(C0_IDLE, C1_IDLE, REQ_IDLE, mmio_answer(tid), 1'b0, 1'b0, 1'b0);
         idle(2);
      end

      test_name = "ase_reset_mid_burst";
      drive(C0_IDLE, C1_IDLE, mmio_read(3), RSP_IDLE, 1'b0, 1'b0, 1'b0);
      drive(C0_IDLE, C1_IDLE, mmio_read(9), RSP_IDLE, 1'b0, 1'b0, 1'b0);
      drive_c1(write_beat(ccip_pkg::eVC_VH0, ccip_pkg::eREQ_WRLINE_M, addr_t'(64),
                          ccip_pkg::eCL_LEN_4, 1'b1));
      drive_c1(write_beat(ccip_pkg::eVC_VH0, ccip_pkg::eREQ_WRLINE_M, addr_t'(65),
                          ccip_pkg::eCL_LEN_4, 1'b0));
      hold_reset(16);
      test_name = "after_reset";
      send_burst(4, F_NONE);
      send_burst(2, F_NONE);
      // Stale TIDs must not time out
      idle(TMO + 8);

      idle(4);
      $display("Test OK");
      $finish;
   end

endmodule

`default_nettype wire
